// File: Makefile
SIM   = verilator
FLAGS = --binary --timing -j 0
TOP   = cache_base_tb
FLIST = cache_base.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: cache_array.sv
// Cache storage array with registered read port and one write port, used for tags and data
`timescale 1ns/100ps

module cache_array #(
  parameter type entry_t = logic [31:0]
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             rd,
  input  logic [cache_pkg::index_bits-1:0] rd_index,
  output entry_t                           rd_data,
  input  logic                             wen,
  input  logic [cache_pkg::index_bits-1:0] wr_index,
  input  entry_t                           wr_data
);

  entry_t mem [cache_pkg::num_lines];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < cache_pkg::num_lines; i++) begin
        mem[i] <= '0;  // Clears the valid bits in the tag array
      end
      rd_data <= '0;
    end else begin
      if (wen) begin
        mem[wr_index] <= wr_data;
      end
      // Same-index write in this cycle is not seen until the next read
      if (rd) begin
        rd_data <= mem[rd_index];
      end
    end
  end

endmodule

// File: cache_base.f
cache_pkg.sv
cache_array.sv
cache_word_counter.sv
cache_dpath.sv
cache_ctrl.sv
cache_base.sv
cache_mem_model.sv
cache_base_tb.sv

// File: cache_base.sv
// Direct-mapped write-back cache top joining control, datapath and word counter
`timescale 1ns/100ps

module cache_base (
  input  logic                 clk,
  input  logic                 rst_n,

  // Processor side
  input  logic                 memreq_val,
  output logic                 memreq_rdy,
  input  cache_pkg::mem_req_t  memreq_msg,
  output logic                 memresp_val,
  input  logic                 memresp_rdy,
  output cache_pkg::mem_resp_t memresp_msg,

  // Memory side
  output logic                 cache_req_val,
  input  logic                 cache_req_rdy,
  output cache_pkg::mem_req_t  cache_req_msg,
  input  logic                 cache_resp_val,
  output logic                 cache_resp_rdy,
  input  cache_pkg::mem_resp_t cache_resp_msg,

  input  logic                 flush,       // Write back all dirty lines
  output logic                 flush_done
);

  cache_pkg::dpath_ctrl_t              ctrl;
  cache_pkg::dpath_status_t            status;
  logic                                word_clear;
  logic                                req_step;
  logic                                resp_step;
  logic [cache_pkg::offset_bits-1:0]   req_count;
  logic                                req_done;
  logic                                resp_done;

  cache_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .cache_req_val  (cache_req_val),
    .cache_req_rdy  (cache_req_rdy),
    .cache_resp_val (cache_resp_val),
    .cache_resp_rdy (cache_resp_rdy),
    .flush          (flush),
    .flush_done     (flush_done),
    .status         (status),
    .ctrl           (ctrl),
    .word_clear     (word_clear),
    .req_step       (req_step),
    .resp_step      (resp_step),
    .req_count      (req_count),
    .req_done       (req_done),
    .resp_done      (resp_done)
  );

  cache_dpath u_dpath (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl           (ctrl),
    .status         (status),
    .memreq_msg     (memreq_msg),
    .memresp_msg    (memresp_msg),
    .cache_req_msg  (cache_req_msg),
    .cache_resp_msg (cache_resp_msg)
  );

  cache_word_counter u_counter (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (word_clear),
    .req_step  (req_step),
    .resp_step (resp_step),
    .req_count (req_count),
    .req_done  (req_done),
    .resp_done (resp_done)
  );

endmodule

// File: cache_base_tb.sv
// Testbench for the direct-mapped write-back cache with shadow memory reference
`timescale 1ns/100ps

module cache_base_tb;

  typedef struct packed {
    cache_pkg::mem_type_e type_;
    logic [31:0]          data;
    logic                 hit_check;  // Response must follow acceptance by 2 cycles
    logic [31:0]          cycle;
  } expect_t;

  logic                 clk;
  logic                 rst_n;
  logic                 memreq_val;
  logic                 memreq_rdy;
  cache_pkg::mem_req_t  memreq_msg;
  logic                 memresp_val;
  logic                 memresp_rdy;
  cache_pkg::mem_resp_t memresp_msg;
  logic                 cache_req_val;
  logic                 cache_req_rdy;
  cache_pkg::mem_req_t  cache_req_msg;
  logic                 cache_resp_val;
  logic                 cache_resp_rdy;
  cache_pkg::mem_resp_t cache_resp_msg;
  logic                 flush;
  logic                 flush_done;
  logic                 stall;

  logic [31:0] lfsr_q = 32'h32d9_cf33;
  logic [31:0] shadow [256];
  bit          written [256];
  expect_t     exp_q [$];
  int          cyc = 0;
  int          resp_seen = 0;
  int          resp_errs = 0;
  int          check_errs = 0;
  int          timeouts = 0;

  cache_base u_cache_base (.*);

  cache_mem_model u_mem (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall          (stall),
    .cache_req_val  (cache_req_val),
    .cache_req_rdy  (cache_req_rdy),
    .cache_req_msg  (cache_req_msg),
    .cache_resp_val (cache_resp_val),
    .cache_resp_rdy (cache_resp_rdy),
    .cache_resp_msg (cache_resp_msg)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Expected word from the last write or the memory's initial fill
  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    if (written[addr[9:2]]) begin
      return shadow[addr[9:2]];
    end
    return {22'b0, addr[11:2]} ^ 32'h5a3c_96e1;
  endfunction

  task automatic timed_out(input string what);
    $display("timeout while waiting for %s at %0t", what, $time);
    timeouts++;
  endtask

  task automatic access(input cache_pkg::mem_type_e t, input logic [31:0] a,
                        input logic [31:0] d, input logic hit_check);
    int          n;
    int          seen;
    expect_t     e;
    logic [31:0] r;
    if (timeouts != 0) return;
    seen = resp_seen;
    memreq_val <= 1'b1;
    memreq_msg <= '{type_: t, addr: a, data: d};
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!memreq_rdy && n < 200);
    if (!memreq_rdy) begin
      timed_out("request accept");
      return;
    end
    memreq_val  <= 1'b0;
    e.type_     = t;
    e.data      = (t == cache_pkg::write) ? '0 : ref_word(a);
    e.hit_check = hit_check;
    e.cycle     = cyc;
    exp_q.push_back(e);
    if (t == cache_pkg::write) begin
      shadow[a[9:2]]  = d;
      written[a[9:2]] = 1'b1;
    end
    n = 0;
    while (resp_seen == seen && n < 1000) begin
      take_bits(1, r);
      memresp_rdy <= !stall || r[0];
      @(posedge clk);
      n++;
    end
    if (resp_seen == seen) timed_out("processor response");
  endtask

  task automatic random_access();
    logic [31:0] w;
    logic [31:0] t;
    logic [31:0] d;
    take_bits(8, w);  // 256 words across 64 lines of address space
    take_bits(1, t);
    take_bits(32, d);
    access(t[0] ? cache_pkg::write : cache_pkg::read, {22'b0, w[7:0], 2'b00}, d, 1'b0);
  endtask

  task automatic do_flush();
    int n;
    if (timeouts != 0) return;
    flush <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!flush_done && n < 5000);
    if (!flush_done) begin
      timed_out("flush_done");
      return;
    end
    flush <= 1'b0;
    repeat (20) begin
      @(posedge clk);
      assert (!cache_req_val && !flush_done) else begin
        check_errs++;
        $display("memory request or extra flush_done after flush at %0t", $time);
      end
    end
    for (int i = 0; i < 256; i++) begin
      assert (u_mem.mem[i] == ref_word(i * 4)) else begin
        check_errs++;
        $display("mismatch at %0t: memory word %0d is %h, expected %h", $time, i,
                 u_mem.mem[i], ref_word(i * 4));
      end
    end
  endtask

  // Compare every accepted response against the expected queue
  always @(posedge clk) begin : compare_resp
    expect_t e;
    if (rst_n && memresp_val && memresp_rdy) begin
      assert (exp_q.size() != 0) else begin
        resp_errs++;
        $display("response with no request outstanding at %0t", $time);
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (memresp_msg.type_ == e.type_ && memresp_msg.data == e.data) else begin
          resp_errs++;
          $display("mismatch at %0t: response %h, expected %h", $time, memresp_msg.data,
                   e.data);
        end
        if (e.hit_check) begin
          assert (cyc - e.cycle == 2) else begin
            resp_errs++;
            $display("mismatch at %0t: hit latency %0d cycles", $time, cyc - e.cycle);
          end
        end
      end
      resp_seen <= resp_seen + 1;
    end
  end

  initial begin
    rst_n       = 1'b0;
    memreq_val  = 1'b0;
    memreq_msg  = '0;
    memresp_rdy = 1'b1;
    flush       = 1'b0;
    stall       = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < 8; i++) begin  // Cold reads
      access(cache_pkg::read, 32'h200 + i * 32'h14, '0, 1'b0);
    end
    access(cache_pkg::write, 32'h40, 32'hdead_beef, 1'b0);
    access(cache_pkg::read, 32'h40, '0, 1'b1);
    access(cache_pkg::read, 32'h44, '0, 1'b1);
    // Same index with a different tag
    access(cache_pkg::write, 32'h84, 32'h1234_5678, 1'b0);
    access(cache_pkg::write, 32'h184, 32'h8765_4321, 1'b0);
    access(cache_pkg::read, 32'h84, '0, 1'b0);
    repeat (40) random_access();
    do_flush();
    stall <= 1'b1;
    repeat (2000) random_access();
    stall <= 1'b0;
    do_flush();
    $display("errors: %0d response, %0d check, %0d timeout", resp_errs, check_errs, timeouts);
    if (resp_errs + check_errs + timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: cache_ctrl.sv
// Cache control FSM sequencing hits, spill, refill, response and flush
`timescale 1ns/100ps

module cache_ctrl (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              memreq_val,
  output logic                              memreq_rdy,
  output logic                              memresp_val,
  input  logic                              memresp_rdy,
  output logic                              cache_req_val,
  input  logic                              cache_req_rdy,
  input  logic                              cache_resp_val,
  output logic                              cache_resp_rdy,
  input  logic                              flush,
  output logic                              flush_done,
  input  cache_pkg::dpath_status_t          status,
  output cache_pkg::dpath_ctrl_t            ctrl,
  output logic                              word_clear,
  output logic                              req_step,
  output logic                              resp_step,
  input  logic [cache_pkg::offset_bits-1:0] req_count,
  input  logic                              req_done,
  input  logic                              resp_done
);

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_spill,
    st_refill,
    st_access,
    st_respond,
    st_flush_read,
    st_flush_check,
    st_flush_spill
  } state_e;

  state_e                           state;
  state_e                           state_next;
  logic [cache_pkg::index_bits-1:0] flush_q;     // Line walked by flush
  logic [cache_pkg::index_bits-1:0] flush_next;
  logic                             line_done;
  logic                             victim_spill;

  assign line_done    = req_done && resp_done;
  assign victim_spill = status.victim_valid && status.victim_dirty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      flush_q <= '0;
    end else begin
      state   <= state_next;
      flush_q <= flush_next;
    end
  end

  always_comb begin
    state_next       = state;
    flush_next       = flush_q;
    ctrl             = '0;
    ctrl.flush_index = flush_q;
    ctrl.word_index  = req_count;
    memreq_rdy       = 1'b0;
    memresp_val      = 1'b0;
    cache_req_val    = 1'b0;
    cache_resp_rdy   = 1'b0;
    flush_done       = 1'b0;
    word_clear       = 1'b0;

    // Memory-side word transfers, shared by every line move
    if (state inside {st_spill, st_refill, st_flush_spill}) begin
      cache_req_val  = !req_done;
      cache_resp_rdy = !resp_done;
    end
    req_step  = cache_req_val && cache_req_rdy;
    resp_step = cache_resp_val && cache_resp_rdy;

    case (state)
      st_idle: begin
        memreq_rdy = 1'b1;
        if (memreq_val) begin  // Request wins over flush
          ctrl.req_en  = 1'b1;
          ctrl.tag_rd  = 1'b1;
          ctrl.data_rd = 1'b1;
          state_next   = st_tag_check;
        end else if (flush) begin
          flush_next = '0;
          state_next = st_flush_read;
        end
      end
      st_tag_check: begin
        word_clear = 1'b1;
        if (status.hit) begin
          if (status.req_write) begin
            ctrl.tag_wen   = 1'b1;
            ctrl.tag_valid = 1'b1;
            ctrl.tag_dirty = 1'b1;
            ctrl.data_wen  = 1'b1;
            ctrl.word_sel  = 1'b1;
          end
          state_next = st_respond;
        end else if (victim_spill) begin
          state_next = st_spill;
        end else begin
          state_next = st_refill;
        end
      end
      st_spill: begin
        ctrl.mem_req_write = 1'b1;
        if (line_done) begin
          word_clear = 1'b1;
          state_next = st_refill;
        end
      end
      st_refill: begin
        ctrl.line_en = resp_step;
        if (line_done) begin
          state_next = st_access;
        end
      end
      st_access: begin
        ctrl.tag_wen   = 1'b1;
        ctrl.tag_valid = 1'b1;
        ctrl.tag_dirty = status.req_write;
        ctrl.data_wen  = 1'b1;
        ctrl.word_sel  = status.req_write;  // Merge the store word into the new line
        state_next     = st_respond;
      end
      st_respond: begin
        memresp_val = 1'b1;
        if (memresp_rdy) begin
          state_next = st_idle;
        end
      end
      st_flush_read: begin
        ctrl.line_sel = 1'b1;
        ctrl.tag_rd   = 1'b1;
        ctrl.data_rd  = 1'b1;
        state_next    = st_flush_check;
      end
      st_flush_check: begin
        ctrl.line_sel = 1'b1;
        if (victim_spill) begin
          word_clear = 1'b1;
          state_next = st_flush_spill;
        end else if (&flush_q) begin  // Last line
          flush_done = 1'b1;
          state_next = st_idle;
        end else begin
          // Clean line, read the next one right away
          flush_next       = flush_q + 1'b1;
          ctrl.flush_index = flush_next;
          ctrl.tag_rd      = 1'b1;
          ctrl.data_rd     = 1'b1;
        end
      end
      st_flush_spill: begin
        ctrl.line_sel      = 1'b1;
        ctrl.mem_req_write = 1'b1;
        if (line_done) begin
          ctrl.tag_wen   = 1'b1;
          ctrl.tag_valid = 1'b1;  // Line stays valid, only dirty clears
          if (&flush_q) begin
            flush_done = 1'b1;
            state_next = st_idle;
          end else begin
            flush_next = flush_q + 1'b1;
            state_next = st_flush_read;
          end
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

endmodule

// File: cache_dpath.sv
// Cache datapath with request register, tag and data arrays, tag compare and line merge
`timescale 1ns/100ps

module cache_dpath (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cache_pkg::dpath_ctrl_t   ctrl,
  output cache_pkg::dpath_status_t status,
  input  cache_pkg::mem_req_t      memreq_msg,
  output cache_pkg::mem_resp_t     memresp_msg,
  output cache_pkg::mem_req_t      cache_req_msg,
  input  cache_pkg::mem_resp_t     cache_resp_msg
);

  cache_pkg::mem_req_t                req_q;
  cache_pkg::line_t                   line_q;
  cache_pkg::line_t                   data_rd_data;
  cache_pkg::line_t                   line_base;
  cache_pkg::line_t                   line_merged;
  cache_pkg::line_t                   line_wr;
  cache_pkg::tag_entry_t              tag_rd_data;
  cache_pkg::tag_entry_t              tag_wr_data;
  logic [cache_pkg::tag_bits-1:0]     req_tag;
  logic [cache_pkg::index_bits-1:0]   req_index;
  logic [cache_pkg::offset_bits-1:0]  req_offset;
  logic [cache_pkg::index_bits-1:0]   in_index;
  logic [cache_pkg::index_bits-1:0]   line_index;
  logic [cache_pkg::index_bits-1:0]   rd_index;
  logic [cache_pkg::tag_bits-1:0]     mem_tag;
  logic [cache_pkg::word_bits-1:0]    resp_word;

  always_ff @(posedge clk) begin
    if (ctrl.req_en) begin
      req_q <= memreq_msg;
    end
    // Responses arrive in word order, so after a full line word 0 sits at the bottom
    if (ctrl.line_en) begin
      line_q <= {cache_resp_msg.data, line_q[cache_pkg::words_per_line-1:1]};
    end
  end

  // Address fields
  assign req_offset = req_q.addr[cache_pkg::byte_bits +: cache_pkg::offset_bits];
  assign req_index  = req_q.addr[cache_pkg::byte_bits + cache_pkg::offset_bits +:
                                 cache_pkg::index_bits];
  assign req_tag    = req_q.addr[cache_pkg::addr_bits-1 -: cache_pkg::tag_bits];
  assign in_index   = memreq_msg.addr[cache_pkg::byte_bits + cache_pkg::offset_bits +:
                                      cache_pkg::index_bits];

  assign line_index = ctrl.line_sel ? ctrl.flush_index : req_index;
  assign rd_index   = ctrl.req_en ? in_index : line_index;  // Read in the accepting cycle

  // Flush keeps the stored tag, normal accesses install the request tag
  assign tag_wr_data.valid = ctrl.tag_valid;
  assign tag_wr_data.dirty = ctrl.tag_dirty;
  assign tag_wr_data.tag   = ctrl.line_sel ? tag_rd_data.tag : req_tag;

  cache_array #(
    .entry_t (cache_pkg::tag_entry_t)
  ) u_tag_array (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd       (ctrl.tag_rd),
    .rd_index (rd_index),
    .rd_data  (tag_rd_data),
    .wen      (ctrl.tag_wen),
    .wr_index (line_index),
    .wr_data  (tag_wr_data)
  );

  cache_array #(
    .entry_t (cache_pkg::line_t)
  ) u_data_array (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd       (ctrl.data_rd),
    .rd_index (rd_index),
    .rd_data  (data_rd_data),
    .wen      (ctrl.data_wen),
    .wr_index (line_index),
    .wr_data  (line_wr)
  );

  assign status.hit          = tag_rd_data.valid && (tag_rd_data.tag == req_tag);
  assign status.victim_dirty = tag_rd_data.dirty;
  assign status.victim_valid = tag_rd_data.valid;
  assign status.req_write    = (req_q.type_ == cache_pkg::write);

  // Hit works on the array line, a miss on the refilled line
  always_comb begin
    line_base               = status.hit ? data_rd_data : line_q;
    line_merged             = line_base;
    line_merged[req_offset] = req_q.data;
  end

  assign line_wr = ctrl.word_sel ? line_merged : line_q;

  assign resp_word         = status.hit ? data_rd_data[req_offset] : line_q[req_offset];
  assign memresp_msg.type_ = req_q.type_;
  assign memresp_msg.data  = status.req_write ? '0 : resp_word;

  // Spill uses the victim tag and line, refill the request tag
  assign mem_tag             = ctrl.mem_req_write ? tag_rd_data.tag : req_tag;
  assign cache_req_msg.type_ = ctrl.mem_req_write ? cache_pkg::write : cache_pkg::read;
  assign cache_req_msg.addr  = {mem_tag, line_index, ctrl.word_index,
                                {cache_pkg::byte_bits{1'b0}}};
  assign cache_req_msg.data  = ctrl.mem_req_write ? data_rd_data[ctrl.word_index] : '0;

endmodule

// File: cache_mem_model.sv
// Testbench word memory with val/rdy port, random request stalls and short response delay
`timescale 1ns/100ps

module cache_mem_model (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,          // Enables random back-pressure and delay
  input  logic                 cache_req_val,
  output logic                 cache_req_rdy,
  input  cache_pkg::mem_req_t  cache_req_msg,
  output logic                 cache_resp_val,
  input  logic                 cache_resp_rdy,
  output cache_pkg::mem_resp_t cache_resp_msg
);

  logic [31:0]          mem [1024];
  cache_pkg::mem_resp_t fifo [8];   // Responses in request order
  logic [3:0]           head;
  logic [3:0]           tail;
  logic [1:0]           delay;
  logic [31:0]          lfsr;
  logic [9:0]           word_addr;

  // Every word starts as its own word address with a fixed scramble
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = i ^ 32'h5a3c_96e1;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  assign word_addr      = cache_req_msg.addr[11:2];
  assign cache_resp_val = (head != tail) && (delay == 2'd0);
  assign cache_resp_msg = fifo[head[2:0]];

  always @(posedge clk) begin : model_seq
    logic [31:0] s;
    logic [1:0]  d;
    if (!rst_n) begin
      lfsr          <= 32'h32d9_cf33;
      head          <= '0;
      tail          <= '0;
      delay         <= '0;
      cache_req_rdy <= 1'b0;
    end else begin
      s             = lfsr_step(lfsr);
      cache_req_rdy <= !stall || s[0];  // About half the cycles stalled
      if (cache_req_val && cache_req_rdy) begin
        if (cache_req_msg.type_ == cache_pkg::write) begin
          mem[word_addr]  <= cache_req_msg.data;
          fifo[tail[2:0]] <= '{type_: cache_pkg::write, data: '0};
        end else begin
          fifo[tail[2:0]] <= '{type_: cache_pkg::read, data: mem[word_addr]};
        end
        tail <= tail + 1'b1;
      end
      if (cache_resp_val && cache_resp_rdy) begin
        head <= head + 1'b1;
        d    = 2'd0;
        if (stall) begin
          for (int i = 0; i < 2; i++) begin
            s = lfsr_step(s);
            d = {d[0], s[0]};
          end
        end
        delay <= d;  // Hold off the next response a little
      end else if (delay != 2'd0) begin
        delay <= delay - 1'b1;
      end
      lfsr <= s;
    end
  end

endmodule

// File: cache_pkg.sv
// Cache package with line geometry, memory message types and control/status structs
package cache_pkg;

  // Geometry of the direct-mapped cache
  localparam int num_lines      = 16;
  localparam int words_per_line = 4;
  localparam int word_bits      = 32;
  localparam int addr_bits      = 32;
  localparam int byte_bits      = 2;   // Byte offset inside a word, ignored
  localparam int offset_bits    = 2;   // Word offset inside a line
  localparam int index_bits     = 4;
  localparam int tag_bits       = 24;  // addr_bits - index_bits - offset_bits - byte_bits

  typedef enum logic {
    read  = 1'b0,
    write = 1'b1
  } mem_type_e;

  // Request message, shared by processor and memory ports
  typedef struct packed {
    mem_type_e              type_;
    logic [addr_bits-1:0]   addr;
    logic [word_bits-1:0]   data;
  } mem_req_t;

  typedef struct packed {
    mem_type_e              type_;
    logic [word_bits-1:0]   data;  // Zero for writes
  } mem_resp_t;

  typedef struct packed {
    logic                   valid;
    logic                   dirty;
    logic [tag_bits-1:0]    tag;
  } tag_entry_t;

  typedef logic [words_per_line-1:0][word_bits-1:0] line_t;

  // Control unit to datapath
  typedef struct packed {
    logic                   req_en;         // Latch processor request
    logic                   tag_rd;
    logic                   tag_wen;
    logic                   tag_dirty;      // New dirty bit on tag write
    logic                   tag_valid;      // New valid bit on tag write
    logic                   data_rd;
    logic                   data_wen;
    logic                   word_sel;       // 1 merges processor word, 0 keeps refill line
    logic                   line_sel;       // 1 selects flush index
    logic [index_bits-1:0]  flush_index;
    logic                   mem_req_write;  // Spill write vs refill read
    logic [offset_bits-1:0] word_index;
    logic                   line_en;        // Shift a refill word into the line register
  } dpath_ctrl_t;

  // Datapath to control unit
  typedef struct packed {
    logic                   hit;
    logic                   victim_dirty;
    logic                   victim_valid;
    logic                   req_write;
  } dpath_status_t;

endpackage

// File: cache_word_counter.sv
// Word counter for spill and refill, tracking requests sent and responses received
`timescale 1ns/100ps

module cache_word_counter (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              clear,
  input  logic                              req_step,
  input  logic                              resp_step,
  output logic [cache_pkg::offset_bits-1:0] req_count,
  output logic                              req_done,
  output logic                              resp_done
);

  // One extra bit so the count can reach a full line
  logic [cache_pkg::offset_bits:0] req_cnt;
  logic [cache_pkg::offset_bits:0] resp_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_cnt  <= '0;
      resp_cnt <= '0;
    end else if (clear) begin
      req_cnt  <= '0;
      resp_cnt <= '0;
    end else begin
      if (req_step && !req_done) begin
        req_cnt <= req_cnt + 1'b1;
      end
      if (resp_step && !resp_done) begin
        resp_cnt <= resp_cnt + 1'b1;
      end
    end
  end

  assign req_count = req_cnt[cache_pkg::offset_bits-1:0];  // Word index of next request

  // Top bit set once all words of the line are counted
  assign req_done  = req_cnt[cache_pkg::offset_bits];
  assign resp_done = resp_cnt[cache_pkg::offset_bits];

endmodule
